// File: Bender.yml
package:
  name: accum_cpu

sources:
  - logic/accum_cpu_pkg.sv
  - logic/mem_port_if.sv
  - logic/sram_1p.sv
  - logic/mem_arbiter.sv
  - logic/cpu_control.sv
  - logic/cpu_datapath.sv
  - logic/accum_cpu_top.sv
  - target: test
    files:
      - sim/accum_cpu_tb.sv

// File: accum_cpu.f
logic/accum_cpu_pkg.sv
logic/mem_port_if.sv
logic/sram_1p.sv
logic/mem_arbiter.sv
logic/cpu_control.sv
logic/cpu_datapath.sv
logic/accum_cpu_top.sv
sim/accum_cpu_tb.sv

// File: logic/accum_cpu_pkg.sv
// accumulator processor definitions
package accum_cpu_pkg;

	localparam int DATA_W       = 16; // word width
	localparam int ADDR_W       = 9;  // 512 words per memory
	localparam int OPC_W        = 4;  // top bits of an instruction
	localparam int HOST_CREDITS = 2;  // host buffer slots

	// instruction opcodes, anything unlisted runs as halt
	typedef enum logic [OPC_W-1:0]
	{
		OP_LOAD  = 4'd0,
		OP_STORE = 4'd1,
		OP_ADD   = 4'd2,
		OP_SUB   = 4'd3,
		OP_AND   = 4'd4,
		OP_JMP   = 4'd5,
		OP_JZ    = 4'd6,
		OP_HALT  = 4'd7
	} opcode_t;

	typedef enum logic [2:0]
	{
		ST_IDLE   = 3'd0,
		ST_FETCH  = 3'd1,
		ST_DECODE = 3'd2,
		ST_EXEC   = 3'd3,
		ST_WAIT   = 3'd4,
		ST_HALT   = 3'd5
	} cpu_state_t;

	typedef enum logic
	{
		SEL_INSTR = 1'b0, // instruction memory
		SEL_DATA  = 1'b1  // data memory
	} mem_sel_t;

endpackage

// File: logic/accum_cpu_top.sv
// accumulator processor top level
`timescale 1ns/1ps

module accum_cpu_top
(
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             start,
	input  logic                             host_valid,
	input  logic                             host_write,
	input  accum_cpu_pkg::mem_sel_t          host_sel,
	input  logic [accum_cpu_pkg::ADDR_W-1:0] host_addr,
	input  logic [accum_cpu_pkg::DATA_W-1:0] host_wdata,
	output logic                             host_credit,
	output logic                             host_rvalid,
	output logic [accum_cpu_pkg::DATA_W-1:0] host_rdata,
	output accum_cpu_pkg::cpu_state_t        state,
	output logic                             halted
);
	import accum_cpu_pkg::*;

	opcode_t           opcode;
	logic              acc_zero;
	logic              load_ir;
	logic              pc_inc;
	logic              pc_jump;
	logic              acc_load;
	logic              acc_alu;
	logic              bus_req;
	logic              bus_we;
	mem_sel_t          bus_sel;
	logic              imem_en;
	logic              imem_we;
	logic              dmem_en;
	logic              dmem_we;
	logic [ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata;
	logic [DATA_W-1:0] imem_rdata;
	logic [DATA_W-1:0] dmem_rdata;

	mem_port_if core_bus (); // core side of the shared bus

	cpu_control cpu_control_inst
	(
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.opcode   (opcode),
		.acc_zero (acc_zero),
		.gnt      (core_bus.gnt),
		.rvalid   (core_bus.rvalid),
		.state    (state),
		.halted   (halted),
		.load_ir  (load_ir),
		.pc_inc   (pc_inc),
		.pc_jump  (pc_jump),
		.acc_load (acc_load),
		.acc_alu  (acc_alu),
		.bus_req  (bus_req),
		.bus_we   (bus_we),
		.bus_sel  (bus_sel)
	);

	cpu_datapath cpu_datapath_inst
	(
		.clk      (clk),
		.rst      (rst),
		.load_ir  (load_ir),
		.pc_inc   (pc_inc),
		.pc_jump  (pc_jump),
		.acc_load (acc_load),
		.acc_alu  (acc_alu),
		.bus_req  (bus_req),
		.bus_we   (bus_we),
		.bus_sel  (bus_sel),
		.bus      (core_bus.requester),
		.opcode   (opcode),
		.acc_zero (acc_zero)
	);

	mem_arbiter mem_arbiter_inst
	(
		.clk         (clk),
		.rst         (rst),
		.core        (core_bus.arbiter),
		.host_valid  (host_valid),
		.host_write  (host_write),
		.host_sel    (host_sel),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.host_credit (host_credit),
		.host_rvalid (host_rvalid),
		.host_rdata  (host_rdata),
		.imem_en     (imem_en),
		.imem_we     (imem_we),
		.dmem_en     (dmem_en),
		.dmem_we     (dmem_we),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.imem_rdata  (imem_rdata),
		.dmem_rdata  (dmem_rdata)
	);

	sram_1p imem_inst
	(
		.clk   (clk),
		.en    (imem_en),
		.we    (imem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (imem_rdata)
	);

	sram_1p dmem_inst
	(
		.clk   (clk),
		.en    (dmem_en),
		.we    (dmem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (dmem_rdata)
	);

endmodule

// File: logic/cpu_control.sv
// processor control FSM
`timescale 1ns/1ps

module cpu_control
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	input  accum_cpu_pkg::opcode_t    opcode,
	input  logic                      acc_zero,
	input  logic                      gnt,
	input  logic                      rvalid,
	output accum_cpu_pkg::cpu_state_t state,
	output logic                      halted,
	output logic                      load_ir,
	output logic                      pc_inc,
	output logic                      pc_jump,
	output logic                      acc_load,
	output logic                      acc_alu,
	output logic                      bus_req,
	output logic                      bus_we,
	output accum_cpu_pkg::mem_sel_t   bus_sel
);
	import accum_cpu_pkg::*;

	cpu_state_t next_state;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	assign halted = (state == ST_HALT);

	always_comb
	begin
		next_state = state;
		load_ir    = 1'b0;
		pc_inc     = 1'b0;
		pc_jump    = 1'b0;
		acc_load   = 1'b0;
		acc_alu    = 1'b0;
		bus_req    = 1'b0;
		bus_we     = 1'b0;
		bus_sel    = SEL_INSTR;
		case (state)
			ST_IDLE, ST_HALT:
				if (start)
				begin
					pc_inc     = 1'b1; // both strobes together restart at word 0
					pc_jump    = 1'b1;
					next_state = ST_FETCH;
				end
			ST_FETCH:
			begin
				bus_req = 1'b1;
				if (gnt)
				begin
					pc_inc     = 1'b1; // address already taken by memory
					next_state = ST_DECODE;
				end
			end
			ST_DECODE:
				if (rvalid)
				begin
					load_ir = 1'b1; // opcode comes straight from rdata here
					case (opcode)
						OP_LOAD, OP_STORE, OP_ADD, OP_SUB, OP_AND:
							next_state = ST_EXEC;
						OP_JMP:
						begin
							pc_jump    = 1'b1;
							next_state = ST_FETCH;
						end
						OP_JZ:
						begin
							pc_jump    = acc_zero;
							next_state = ST_FETCH;
						end
						default: next_state = ST_HALT;
					endcase
				end
			ST_EXEC:
			begin
				bus_req = 1'b1;
				bus_sel = SEL_DATA;
				bus_we  = (opcode == OP_STORE);
				if (gnt)
					next_state = (opcode == OP_STORE) ? ST_FETCH : ST_WAIT;
			end
			ST_WAIT:
				if (rvalid)
				begin
					acc_load   = (opcode == OP_LOAD);
					acc_alu    = (opcode != OP_LOAD);
					next_state = ST_FETCH;
				end
			default: next_state = ST_IDLE;
		endcase
	end

endmodule

// File: logic/cpu_datapath.sv
// processor datapath
`timescale 1ns/1ps

module cpu_datapath
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    load_ir,
	input  logic                    pc_inc,
	input  logic                    pc_jump,
	input  logic                    acc_load,
	input  logic                    acc_alu,
	input  logic                    bus_req,
	input  logic                    bus_we,
	input  accum_cpu_pkg::mem_sel_t bus_sel,
	mem_port_if.requester           bus,
	output accum_cpu_pkg::opcode_t  opcode,
	output logic                    acc_zero
);
	import accum_cpu_pkg::*;

	logic [ADDR_W-1:0] pc;
	logic [DATA_W-1:0] ir;
	logic [DATA_W-1:0] instr; // instruction being decoded
	logic [DATA_W-1:0] acc;
	logic [DATA_W-1:0] alu_out;

	// during decode the fresh word is not yet in ir
	assign instr  = load_ir ? bus.rdata : ir;
	assign opcode = opcode_t'(instr[DATA_W-1 -: OPC_W]);

	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= '0;
		else if (pc_jump && pc_inc)
			pc <= '0; // restart
		else if (pc_jump)
			pc <= instr[ADDR_W-1:0];
		else if (pc_inc)
			pc <= pc + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (load_ir)
			ir <= bus.rdata;
	end

	always_comb
	begin
		case (opcode)
			OP_ADD:  alu_out = acc + bus.rdata;
			OP_SUB:  alu_out = acc - bus.rdata;
			OP_AND:  alu_out = acc & bus.rdata;
			default: alu_out = acc;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			acc <= '0;
		else if (acc_load)
			acc <= bus.rdata;
		else if (acc_alu)
			acc <= alu_out;
	end

	assign acc_zero = (acc == '0);

	// fetch from pc, operands from the ir address field
	assign bus.req   = bus_req;
	assign bus.we    = bus_we;
	assign bus.sel   = bus_sel;
	assign bus.addr  = (bus_sel == SEL_INSTR) ? pc : instr[ADDR_W-1:0];
	assign bus.wdata = acc;

endmodule

// File: logic/mem_arbiter.sv
// shared memory bus arbiter
`timescale 1ns/1ps

module mem_arbiter
(
	input  logic                             clk,
	input  logic                             rst,
	mem_port_if.arbiter                      core,
	input  logic                             host_valid,
	input  logic                             host_write,
	input  accum_cpu_pkg::mem_sel_t          host_sel,
	input  logic [accum_cpu_pkg::ADDR_W-1:0] host_addr,
	input  logic [accum_cpu_pkg::DATA_W-1:0] host_wdata,
	output logic                             host_credit,
	output logic                             host_rvalid,
	output logic [accum_cpu_pkg::DATA_W-1:0] host_rdata,
	output logic                             imem_en,
	output logic                             imem_we,
	output logic                             dmem_en,
	output logic                             dmem_we,
	output logic [accum_cpu_pkg::ADDR_W-1:0] mem_addr,
	output logic [accum_cpu_pkg::DATA_W-1:0] mem_wdata,
	input  logic [accum_cpu_pkg::DATA_W-1:0] imem_rdata,
	input  logic [accum_cpu_pkg::DATA_W-1:0] dmem_rdata
);
	import accum_cpu_pkg::*;

	// host request buffer, bounded by the credits
	logic                                 fifo_write [HOST_CREDITS];
	mem_sel_t                             fifo_sel   [HOST_CREDITS];
	logic [ADDR_W-1:0]                    fifo_addr  [HOST_CREDITS];
	logic [DATA_W-1:0]                    fifo_wdata [HOST_CREDITS];
	logic [$clog2(HOST_CREDITS)-1:0]      wr_ptr;
	logic [$clog2(HOST_CREDITS)-1:0]      rd_ptr;
	logic [$clog2(HOST_CREDITS+1)-1:0]    count;
	logic                                 host_pend;
	logic                                 last_host; // host had the last grant
	logic                                 grant_host;
	logic                                 grant_core;
	logic                                 cur_we;
	mem_sel_t                             cur_sel;
	logic                                 rd_core;
	logic                                 rd_host;
	mem_sel_t                             rd_sel;
	logic [DATA_W-1:0]                    rd_word;

	assign host_pend  = (count != '0);
	assign grant_host = host_pend && (!core.req || !last_host);
	assign grant_core = core.req && (!host_pend || last_host);

	always_ff @(posedge clk)
	begin
		if (host_valid)
		begin
			fifo_write[wr_ptr] <= host_write;
			fifo_sel[wr_ptr]   <= host_sel;
			fifo_addr[wr_ptr]  <= host_addr;
			fifo_wdata[wr_ptr] <= host_wdata;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			last_host <= 1'b0;
		end
		else
		begin
			if (host_valid)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
			if (grant_host)
				rd_ptr <= rd_ptr + 1'b1;
			case ({host_valid, grant_host})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (grant_host)
				last_host <= 1'b1;
			else if (grant_core)
				last_host <= 1'b0;
		end
	end

	// route the winner onto the memory bus
	assign cur_we    = grant_host ? fifo_write[rd_ptr] : core.we;
	assign cur_sel   = grant_host ? fifo_sel[rd_ptr] : core.sel;
	assign mem_addr  = grant_host ? fifo_addr[rd_ptr] : core.addr;
	assign mem_wdata = grant_host ? fifo_wdata[rd_ptr] : core.wdata;

	assign imem_en = (grant_host || grant_core) && (cur_sel == SEL_INSTR);
	assign dmem_en = (grant_host || grant_core) && (cur_sel == SEL_DATA);
	assign imem_we = imem_en && cur_we;
	assign dmem_we = dmem_en && cur_we;

	assign core.gnt    = grant_core;
	assign host_credit = grant_host; // slot frees on its grant

	// owner and memory of last cycle's read
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_core <= 1'b0;
			rd_host <= 1'b0;
			rd_sel  <= SEL_INSTR;
		end
		else
		begin
			rd_core <= grant_core && !cur_we;
			rd_host <= grant_host && !cur_we;
			rd_sel  <= cur_sel;
		end
	end

	assign rd_word     = (rd_sel == SEL_INSTR) ? imem_rdata : dmem_rdata;
	assign core.rvalid = rd_core;
	assign core.rdata  = rd_word;
	assign host_rvalid = rd_host;
	assign host_rdata  = rd_word;

endmodule

// File: logic/mem_port_if.sv
// shared memory bus port
`timescale 1ns/1ps

interface mem_port_if;
	import accum_cpu_pkg::*;

	logic              req;    // held until gnt
	logic              we;
	mem_sel_t          sel;    // target memory
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              gnt;
	logic              rvalid; // one cycle after a read gnt
	logic [DATA_W-1:0] rdata;

	modport requester (output req, we, sel, addr, wdata, input gnt, rvalid, rdata);

	modport arbiter (input req, we, sel, addr, wdata, output gnt, rvalid, rdata);

endinterface

// File: logic/sram_1p.sv
// single-port synchronous RAM
`timescale 1ns/1ps

module sram_1p
(
	input  logic                             clk,
	input  logic                             en,
	input  logic                             we,
	input  logic [accum_cpu_pkg::ADDR_W-1:0] addr,
	input  logic [accum_cpu_pkg::DATA_W-1:0] wdata,
	output logic [accum_cpu_pkg::DATA_W-1:0] rdata
);
	import accum_cpu_pkg::*;

	logic [DATA_W-1:0] mem [2**ADDR_W];

	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr]; // q one cycle after the read
		end
	end

endmodule

// File: sim/accum_cpu_tb.sv
// accumulator processor testbench
`timescale 1ns/1ps

module accum_cpu_tb;
	import accum_cpu_pkg::*;

	localparam int MAX_CYCLES = 4000; // about twice the longest sequence
	localparam int LOOP_COUNT = 5;
	localparam int CNT_A      = 100;  // loop counter
	localparam int ONE_A      = 101;
	localparam int STEP_A     = 102;
	localparam int SUM_A      = 103;
	localparam int MASK_A     = 104;
	localparam int SCRATCH_A  = 200;  // data words the program never touches
	localparam int ISPARE_A   = 300;  // instruction words past the program

	logic              clk = 1'b0;
	logic              rst;
	logic              start;
	logic              host_valid;
	logic              host_write;
	mem_sel_t          host_sel;
	logic [ADDR_W-1:0] host_addr;
	logic [DATA_W-1:0] host_wdata;
	logic              host_credit;
	logic              host_rvalid;
	logic [DATA_W-1:0] host_rdata;
	cpu_state_t        state;
	logic              halted;

	logic [DATA_W-1:0] imem_shadow [2**ADDR_W];
	logic [DATA_W-1:0] dmem_shadow [2**ADDR_W];
	logic [DATA_W-1:0] exp_q [$];  // host read data in request order
	logic              pend_q [$]; // write flags of requests still holding a credit
	logic [DATA_W-1:0] exp_data;
	logic              head_is_read = 1'b0;
	int                pend_cnt = 0;
	int                credits = HOST_CREDITS;
	int                errors = 0;
	int                reads_checked = 0;
	int                cycles = 0;
	logic              rst_d = 1'b0;
	logic [31:0]       seed = 32'hf8eef3b1;
	logic [DATA_W-1:0] sum_init;
	logic [DATA_W-1:0] step_val;
	logic [DATA_W-1:0] mask_val;

	always #50 clk = ~clk;

	accum_cpu_top accum_cpu_top_inst
	(
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.host_valid  (host_valid),
		.host_write  (host_write),
		.host_sel    (host_sel),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.host_credit (host_credit),
		.host_rvalid (host_rvalid),
		.host_rdata  (host_rdata),
		.state       (state),
		.halted      (halted)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [DATA_W-1:0] assemble(input opcode_t op, input int addr);
		return {op, 3'b000, ADDR_W'(addr)};
	endfunction

	// one request per call while a credit is held
	task automatic host_access(input logic write, input mem_sel_t sel, input int addr,
		input logic [DATA_W-1:0] data);
		while (credits == 0)
			@(negedge clk);
		host_valid = 1'b1;
		host_write = write;
		host_sel   = sel;
		host_addr  = ADDR_W'(addr);
		host_wdata = data;
		if (write && sel == SEL_INSTR)
			imem_shadow[ADDR_W'(addr)] = data;
		else if (write)
			dmem_shadow[ADDR_W'(addr)] = data;
		else if (sel == SEL_INSTR)
			exp_q.push_back(imem_shadow[ADDR_W'(addr)]);
		else
			exp_q.push_back(dmem_shadow[ADDR_W'(addr)]);
		@(negedge clk);
		host_valid = 1'b0;
	endtask

	task automatic wait_idle;
		while (credits != HOST_CREDITS || exp_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic pulse_start;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// counts down from LOOP_COUNT while folding step and mask into the sum
	task automatic load_program;
		logic [DATA_W-1:0] code [10];
		code[0] = assemble(OP_LOAD, SUM_A);
		code[1] = assemble(OP_ADD, STEP_A);
		code[2] = assemble(OP_AND, MASK_A);
		code[3] = assemble(OP_STORE, SUM_A);
		code[4] = assemble(OP_LOAD, CNT_A);
		code[5] = assemble(OP_SUB, ONE_A);
		code[6] = assemble(OP_STORE, CNT_A);
		code[7] = assemble(OP_JZ, 9);
		code[8] = assemble(OP_JMP, 0);
		code[9] = assemble(OP_HALT, 0);
		for (int i = 0; i < 10; i++)
			host_access(1'b1, SEL_INSTR, i, code[i]);
	endtask

	task automatic init_data;
		host_access(1'b1, SEL_DATA, CNT_A, DATA_W'(LOOP_COUNT));
		host_access(1'b1, SEL_DATA, ONE_A, 16'd1);
		host_access(1'b1, SEL_DATA, STEP_A, step_val);
		host_access(1'b1, SEL_DATA, MASK_A, mask_val);
		host_access(1'b1, SEL_DATA, SUM_A, sum_init);
	endtask

	task automatic read_results;
		host_access(1'b0, SEL_DATA, CNT_A, '0);
		host_access(1'b0, SEL_DATA, SUM_A, '0);
	endtask

	// instruction set model that leaves the final data words in the shadow
	task automatic run_model;
		logic [ADDR_W-1:0] pc;
		logic [DATA_W-1:0] acc;
		logic [DATA_W-1:0] instr;
		logic [ADDR_W-1:0] arg;
		opcode_t           opc;
		logic              done;
		int                steps;
		pc    = '0;
		acc   = '0;
		done  = 1'b0;
		steps = 0;
		while (!done && steps < 1000)
		begin
			instr = imem_shadow[pc];
			opc   = opcode_t'(instr[DATA_W-1 -: OPC_W]);
			arg   = instr[ADDR_W-1:0];
			pc    = pc + 1'b1;
			steps++;
			case (opc)
				OP_LOAD:  acc = dmem_shadow[arg];
				OP_STORE: dmem_shadow[arg] = acc;
				OP_ADD:   acc = acc + dmem_shadow[arg];
				OP_SUB:   acc = acc - dmem_shadow[arg];
				OP_AND:   acc = acc & dmem_shadow[arg];
				OP_JMP:   pc = arg;
				OP_JZ:    pc = (acc == '0) ? arg : pc;
				default:  done = 1'b1; // halt and unused codes
			endcase
		end
		if (!done)
		begin
			errors++;
			$display("the instruction set model never reached a halt");
		end
	endtask

	always @(posedge clk)
	begin
		if (rst)
			credits <= HOST_CREDITS;
		else
			credits <= credits - int'(host_valid) + int'(host_credit);
	end

	// requests waiting for their credit pulse in arrival order
	always @(posedge clk)
	begin
		if (rst)
			pend_q.delete();
		else
		begin
			if (host_credit && pend_q.size() != 0)
				void'(pend_q.pop_front());
			if (host_valid)
				pend_q.push_back(host_write);
		end
		head_is_read = (pend_q.size() != 0) && !pend_q[0];
		pend_cnt     = pend_q.size();
	end

	always @(posedge clk)
	begin
		rst_d <= rst;
		if (!rst && host_rvalid)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("%0t host read data came back with no read outstanding", $time);
			end
			else
			begin
				exp_data = exp_q.pop_front();
				reads_checked++;
				a_read_data: assert (host_rdata === exp_data)
				else
				begin
					errors++;
					$display("ERR %0t host_rdata expected %h got %h", $time, exp_data, host_rdata);
				end
			end
		end
	end

	a_reset_state: assert property (@(posedge clk) rst_d |-> state == ST_IDLE)
	else
	begin
		errors++;
		$display("ERR %0t state expected %0d got %0d", $time, ST_IDLE, $sampled(state));
	end

	a_reset_flags: assert property (@(posedge clk)
		rst_d |-> {host_credit, host_rvalid, halted} == 3'b000)
	else
	begin
		errors++;
		$display("ERR %0t host_credit/host_rvalid/halted expected 000 got %b%b%b", $time,
			$sampled(host_credit), $sampled(host_rvalid), $sampled(halted));
	end

	a_credit_range: assert property (@(posedge clk) credits >= 0 && credits <= HOST_CREDITS)
	else
	begin
		errors++;
		$display("ERR %0t credits expected 0 to %0d got %0d", $time, HOST_CREDITS,
			$sampled(credits));
	end

	a_credit_owed: assert property (@(posedge clk) disable iff (rst) host_credit |-> pend_cnt != 0)
	else
	begin
		errors++;
		$display("%0t host_credit pulsed with no host request outstanding", $time);
	end

	a_read_return: assert property (@(posedge clk) disable iff (rst)
		host_credit && head_is_read |=> host_rvalid)
	else
	begin
		errors++;
		$display("ERR %0t host_rvalid expected 1 got %b", $time, $sampled(host_rvalid));
	end

	a_rvalid_source: assert property (@(posedge clk) disable iff (rst)
		host_rvalid |-> $past(host_credit && head_is_read))
	else
	begin
		errors++;
		$display("ERR %0t host_rvalid expected 0 got %b", $time, $sampled(host_rvalid));
	end

	// halted holds until a start restarts the program
	a_halted: assert property (@(posedge clk) disable iff (rst)
		halted |=> halted == !$past(start))
	else
	begin
		errors++;
		$display("ERR %0t halted expected %b got %b", $time, !$sampled(halted),
			$sampled(halted));
	end

	a_start: assert property (@(posedge clk) disable iff (rst)
		start && (state == ST_IDLE || state == ST_HALT) |=> state == ST_FETCH)
	else
	begin
		errors++;
		$display("ERR %0t state expected %0d got %0d", $time, ST_FETCH, $sampled(state));
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin
		rst        = 1'b1;
		start      = 1'b0;
		host_valid = 1'b0;
		host_write = 1'b0;
		host_sel   = SEL_INSTR;
		host_addr  = '0;
		host_wdata = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// fill host-only words in both memories and read them back at random
		for (int i = 0; i < 64; i++)
		begin
			seed = xorshift(seed);
			host_access(1'b1, SEL_DATA, SCRATCH_A + i, seed[DATA_W-1:0]);
		end
		for (int i = 0; i < 32; i++)
		begin
			seed = xorshift(seed);
			host_access(1'b1, SEL_INSTR, ISPARE_A + i, seed[DATA_W-1:0]);
		end
		for (int i = 0; i < 48; i++)
		begin
			seed = xorshift(seed);
			if (seed[31])
				host_access(1'b0, SEL_DATA, SCRATCH_A + int'(seed[5:0]), '0);
			else
				host_access(1'b0, SEL_INSTR, ISPARE_A + int'(seed[4:0]), '0);
		end
		wait_idle();

		// first program run from idle
		seed     = xorshift(seed);
		step_val = seed[DATA_W-1:0];
		seed     = xorshift(seed);
		mask_val = seed[DATA_W-1:0] | 16'h00f0; // keep some sum bits alive
		seed     = xorshift(seed);
		sum_init = seed[DATA_W-1:0];
		load_program();
		init_data();
		wait_idle();
		run_model();
		pulse_start();
		while (!halted)
			@(negedge clk);
		read_results();
		wait_idle();

		// restart from halt with host reads competing for the bus
		init_data();
		wait_idle();
		run_model();
		pulse_start();
		while (!halted)
		begin
			seed = xorshift(seed);
			host_access(1'b0, SEL_DATA, SCRATCH_A + int'(seed[5:0]), '0);
		end
		wait_idle();
		read_results();
		wait_idle();

		$display("%0d host reads checked, %0d errors", reads_checked, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
